// File: build.f
+incdir+source
source/epu_pkg.sv
source/epu_if.sv
source/msr_access.sv
source/exc_commit.sv
source/msr_file.sv
source/irq_ctrl.sv
source/tsc_timer.sv
source/epu_top.sv
sim/epu_tb.sv

// File: sim/epu_input.txt
# W or R: bank offset_bit data_or_expected; E: exc_index epc nepc lsa flush_byte_addr
# I: irqs expected_irq_async; T: tcr cycle_bound; all fields hex
W 0 0 000001b5
R 0 0 000001b5
W 0 2 00000163
R 0 2 00000163
W 0 3 12345678
R 0 3 12345678
W 0 4 89abcdef
R 0 4 89abcdef
W 6 0 0000000f
R 6 0 0000000f
E 1 00000400 00000401 00000000 00000100
R 0 3 00001004
R 0 2 000001b5
R 0 0 00000115
W 0 2 000000e0
E 0 00000000 00000000 00000000 00001004
R 0 0 000001e5
E 4 00000800 00000801 deadbeef 00000400
R 0 4 00002000
E 6 00000900 00000901 cafef00d 00000600
R 0 4 cafef00d
R 0 3 00002400
W 0 0 00000020
I 10 1
I 01 0
I 11 1
R 6 1 00000011
I 00 0
W 7 0 00000000
T c0000010 00000014
R 7 1 c0000010

// File: sim/epu_tb.sv
// Testbench epu_tb: runs the MSR operation script against epu_top and checks the responses
`timescale 1ns/1ps
`include "epu_defines.svh"

module epu_tb;

   logic                    clk;
   logic                    arst_n;
   logic                    stall;
   logic                    ex_valid;
   logic [`EPU_OPC_W-1:0]   ex_opc;
   logic [`EPU_DW-1:0]      ex_operand1;
   logic [`EPU_DW-1:0]      ex_operand2;
   logic [`EPU_DW-1:0]      ex_imm;
   logic [`EPU_EXC_W-1:0]   commit_exc;
   logic [`EPU_PC_W-1:0]    commit_epc;
   logic [`EPU_PC_W-1:0]    commit_nepc;
   logic [`EPU_DW-1:0]      commit_lsa;
   logic                    commit_flush_tlb;
   logic [`EPU_PC_W-1:0]    commit_flush_tlb_npc;
   logic [`EPU_NUM_IRQ-1:0] irqs;
   logic [`EPU_DW-1:0]      epu_dout;
   logic                    epu_dout_valid;
   logic                    epu_eret;
   logic                    epu_esyscall;
   logic                    exc_flush;
   logic [`EPU_PC_W-1:0]    exc_flush_tgt;
   logic                    irq_async;
   logic                    tsc_irq;

   integer      seed;
   integer      fd;
   int unsigned cycle_cnt = 0;
   int unsigned cycle_limit = 0;

   // One entry per script line, unused fields are zero
   logic [7:0]  op_q [$];
   logic [31:0] f0_q [$];
   logic [31:0] f1_q [$];
   logic [31:0] f2_q [$];
   logic [31:0] f3_q [$];
   logic [31:0] f4_q [$];

   epu_top dut (
      .clk(clk), .arst_n(arst_n), .stall(stall),
      .ex_valid(ex_valid), .ex_opc(ex_opc),
      .ex_operand1(ex_operand1), .ex_operand2(ex_operand2), .ex_imm(ex_imm),
      .commit_exc(commit_exc), .commit_epc(commit_epc), .commit_nepc(commit_nepc),
      .commit_lsa(commit_lsa), .commit_flush_tlb(commit_flush_tlb),
      .commit_flush_tlb_npc(commit_flush_tlb_npc), .irqs(irqs),
      .epu_dout(epu_dout), .epu_dout_valid(epu_dout_valid),
      .epu_eret(epu_eret), .epu_esyscall(epu_esyscall),
      .exc_flush(exc_flush), .exc_flush_tgt(exc_flush_tgt),
      .irq_async(irq_async), .tsc_irq(tsc_irq)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
         $display("Timeout: the script did not finish within %0d cycles", cycle_limit);
         $display("Errors found");
         $fatal(1, "Run did not finish");
      end
   end

   task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("Fail at %0t: %s, got %h, expected %h", $time, what, got, exp);
         $display("Errors found");
         $fatal(1, "Check failed");
      end
   endtask

   task automatic drive_idle();
      ex_valid    = 1'b0;
      ex_opc      = '0;
      ex_operand1 = '0;
      ex_operand2 = '0;
      ex_imm      = '0;
   endtask

   // Bank number through operand1, one-hot offset through the immediate
   task automatic drive_addr(input logic [31:0] bank, input logic [31:0] off);
      ex_operand1 = (bank & ((32'd1 << `EPU_BANK_AW) - 1)) << `EPU_BANK_OFF_AW;
      ex_imm      = 32'd1 << off;
   endtask

   task automatic msr_write(input logic [31:0] bank, input logic [31:0] off,
                            input logic [31:0] data);
      logic [31:0] word;
      logic [31:0] psr_mask;
      psr_mask = (32'd1 << `EPU_PSR_DW) - 1;
      word     = data;
      // PSR and EPSR keep only their low bits, the rest is noise
      if (bank == `EPU_BANK_PS && (off == `EPU_MSR_PSR || off == `EPU_MSR_EPSR)) begin
         word = ($random(seed) & ~psr_mask) | (data & psr_mask);
      end
      drive_addr(bank, off);
      ex_operand2               = word;
      ex_opc                    = '0;
      ex_opc[`EPU_OP_WMSR]      = 1'b1;
      ex_valid                  = 1'b1;
      @(posedge clk);
      #2;
      drive_idle();
      // Commit cycle, target register loads at its end
      @(posedge clk);
      #2;
   endtask

   task automatic msr_read_check(input logic [31:0] bank, input logic [31:0] off,
                                 input logic [31:0] exp);
      drive_addr(bank, off);
      ex_opc               = '0;
      ex_opc[`EPU_OP_RMSR] = 1'b1;
      ex_valid             = 1'b1;
      #5;
      check_val({31'b0, epu_dout_valid}, 32'd1, "epu_dout_valid low on a read");
      check_val(epu_dout, exp, $sformatf("read of bank %0h offset bit %0d", bank, off));
      @(posedge clk);
      #2;
      drive_idle();
   endtask

   task automatic commit_exception(input logic [31:0] idx, input logic [31:0] epc,
                                   input logic [31:0] nepc, input logic [31:0] lsa,
                                   input logic [31:0] exp_tgt);
      logic is_eret;
      logic is_syscall;
      is_eret    = (idx == `EPU_EXC_ERET);
      is_syscall = (idx == `EPU_EXC_ESYSCALL);
      // Matching instruction in execute raises its decode strobe
      ex_opc                   = '0;
      ex_opc[`EPU_OP_ERET]     = is_eret;
      ex_opc[`EPU_OP_ESYSCALL] = is_syscall;
      ex_valid                 = is_eret | is_syscall;
      commit_exc      = '0;
      commit_exc[idx] = 1'b1;
      commit_epc      = epc[`EPU_PC_W-1:0];
      commit_nepc     = nepc[`EPU_PC_W-1:0];
      commit_lsa      = lsa;
      #5;
      check_val({31'b0, epu_eret}, {31'b0, is_eret},
                $sformatf("epu_eret for exception %0d", idx));
      check_val({31'b0, epu_esyscall}, {31'b0, is_syscall},
                $sformatf("epu_esyscall for exception %0d", idx));
      check_val({31'b0, exc_flush}, 32'd1, $sformatf("no flush for exception %0d", idx));
      check_val({exc_flush_tgt, 2'b00}, exp_tgt, $sformatf("flush target of exception %0d", idx));
      @(posedge clk);
      #2;
      commit_exc = '0;
      drive_idle();
   endtask

   task automatic irq_check(input logic [31:0] lines, input logic [31:0] exp);
      irqs = lines[`EPU_NUM_IRQ-1:0];
      #5;
      check_val({31'b0, irq_async}, exp, $sformatf("irq_async for irqs %h", irqs));
      @(posedge clk);
      #2;
   endtask

   task automatic timer_check(input logic [31:0] tcr_val, input logic [31:0] bound);
      logic [31:0] waited;
      msr_write(`EPU_BANK_TSC, `EPU_MSR_TCR, tcr_val);
      waited = 0;
      while (tsc_irq !== 1'b1 && waited < bound) begin
         @(posedge clk);
         #2;
         waited = waited + 1;
      end
      check_val({31'b0, tsc_irq}, 32'd1, "tsc_irq did not rise within the bound");
      drive_addr(`EPU_BANK_TSC, `EPU_MSR_TSR);
      ex_opc               = '0;
      ex_opc[`EPU_OP_RMSR] = 1'b1;
      ex_valid             = 1'b1;
      #5;
      check_val({31'b0, epu_dout[`EPU_TCR_CNT_W-1:0] >= tcr_val[`EPU_TCR_CNT_W-1:0]}, 32'd1,
                "TSR below the compare value");
      @(posedge clk);
      #2;
      drive_idle();
   endtask

   function automatic int field_count(input logic [7:0] op_c);
      case (op_c)
         "W", "R": return 3;
         "E":      return 5;
         "I", "T": return 2;
         default:  return 0;
      endcase
   endfunction

   task automatic load_script();
      logic [7:0]    op_c;
      logic [1023:0] line_buf;
      logic [31:0]   fld [5];
      logic [31:0]   val;
      int            n;
      int            nf;
      int            k;
      bit            done;
      fd = $fopen("sim/epu_input.txt", "r");
      if (fd == 0) begin
         $display("Could not open the operation script sim/epu_input.txt");
         $display("Errors found");
         $fatal(1, "Missing script");
      end
      done = 1'b0;
      while (!done) begin
         n = $fscanf(fd, " %c", op_c);
         if (n != 1) begin
            done = 1'b1;
         end else if (op_c == "#") begin
            n = $fgets(line_buf, fd);
         end else begin
            nf = field_count(op_c);
            if (nf == 0) begin
               $display("Unknown operation letter %c in the script", op_c);
               $display("Errors found");
               $fatal(1, "Bad script");
            end
            for (k = 0; k < 5; k++) begin
               fld[k] = '0;
            end
            for (k = 0; k < nf; k++) begin
               n = $fscanf(fd, " %h", val);
               if (n != 1) begin
                  $display("Script line for operation %c has too few fields", op_c);
                  $display("Errors found");
                  $fatal(1, "Bad script");
               end
               fld[k] = val;
            end
            op_q.push_back(op_c);
            f0_q.push_back(fld[0]);
            f1_q.push_back(fld[1]);
            f2_q.push_back(fld[2]);
            f3_q.push_back(fld[3]);
            f4_q.push_back(fld[4]);
         end
      end
      $fclose(fd);
   endtask

   initial begin
      seed                 = 32'hca3acdf5;
      clk                  = 1'b0;
      arst_n               = 1'b0;
      stall                = 1'b0;
      commit_exc           = '0;
      commit_epc           = '0;
      commit_nepc          = '0;
      commit_lsa           = '0;
      commit_flush_tlb     = 1'b0;
      commit_flush_tlb_npc = '0;
      irqs                 = '0;
      drive_idle();
      load_script();
      cycle_limit = 40 * op_q.size();
      repeat (2) @(posedge clk);
      #2;
      arst_n = 1'b1;
      #5;
      // Quiet outputs out of reset
      check_val({31'b0, exc_flush}, 32'd0, "exc_flush high after reset");
      check_val({31'b0, irq_async}, 32'd0, "irq_async high after reset");
      check_val({31'b0, tsc_irq}, 32'd0, "tsc_irq high after reset");
      check_val({31'b0, epu_dout_valid}, 32'd0, "epu_dout_valid high after reset");
      @(posedge clk);
      #2;
      foreach (op_q[i]) begin
         case (op_q[i])
            "W": msr_write(f0_q[i], f1_q[i], f2_q[i]);
            "R": msr_read_check(f0_q[i], f1_q[i], f2_q[i]);
            "E": commit_exception(f0_q[i], f1_q[i], f2_q[i], f3_q[i], f4_q[i]);
            "I": irq_check(f0_q[i], f1_q[i]);
            default: timer_check(f0_q[i], f1_q[i]);
         endcase
      end
      $display("No errors");
      $finish;
   end

endmodule

// File: source/epu_defines.svh
// Widths, MSR bank codes, offset select bits, opcode bits, exception indices and vectors
`ifndef EPU_DEFINES_SVH
`define EPU_DEFINES_SVH

`define EPU_DW            32
`define EPU_PC_W          30
`define EPU_PSR_DW        10
`define EPU_NUM_IRQ       8

// MSR address split
`define EPU_BANK_AW       5
`define EPU_BANK_OFF_AW   9

`define EPU_BANK_PS       5'd0
`define EPU_BANK_IRQC     5'd6
`define EPU_BANK_TSC      5'd7

// One-hot offset bits within a bank
`define EPU_MSR_PSR       0
`define EPU_MSR_EPSR      2
`define EPU_MSR_EPC       3
`define EPU_MSR_ELSA      4
`define EPU_MSR_IMR       0
`define EPU_MSR_IRR       1
`define EPU_MSR_TSR       0
`define EPU_MSR_TCR       1

`define EPU_OPC_W         4
`define EPU_OP_RMSR       0
`define EPU_OP_WMSR       1
`define EPU_OP_ERET       2
`define EPU_OP_ESYSCALL   3

`define EPU_EXC_W         9
`define EPU_EXC_ERET      0
`define EPU_EXC_ESYSCALL  1
`define EPU_EXC_EINSN     2
`define EPU_EXC_EIPF      3
`define EPU_EXC_EITM      4
`define EPU_EXC_EIRQ      5
`define EPU_EXC_EDTM      6
`define EPU_EXC_EDPF      7
`define EPU_EXC_EALIGN    8

// Vector byte addresses
`define EPU_VEC_ESYSCALL  32'h0000_0100
`define EPU_VEC_EINSN     32'h0000_0200
`define EPU_VEC_EIPF      32'h0000_0300
`define EPU_VEC_EITM      32'h0000_0400
`define EPU_VEC_EIRQ      32'h0000_0500
`define EPU_VEC_EDTM      32'h0000_0600
`define EPU_VEC_EDPF      32'h0000_0700
`define EPU_VEC_EALIGN    32'h0000_0800

`define EPU_TCR_EN        31
`define EPU_TCR_IE        30
`define EPU_TCR_CNT_W     28

`endif

// File: source/epu_if.sv
// Interfaces msr_wr_if (committed MSR write bundle) and msr_upd_if (register update commands)
`timescale 1ns/1ps
`include "epu_defines.svh"

interface msr_wr_if;
   logic psr_we;
   logic epsr_we;
   logic epc_we;
   logic elsa_we;
   logic imr_we;
   logic tsr_we;
   logic tcr_we;
   epu_pkg::wmsr_dat_u dat;

   modport src (output psr_we, epsr_we, epc_we, elsa_we, imr_we, tsr_we, tcr_we, dat);
   modport dst (input psr_we, epsr_we, epc_we, elsa_we, imr_we, tsr_we, tcr_we, dat);
endinterface

interface msr_upd_if;
   logic                   psr_we;
   logic [`EPU_PSR_DW-1:0] psr_nxt;
   logic                   epsr_we;
   logic [`EPU_PSR_DW-1:0] epsr_nxt;
   logic                   epc_we;
   logic [`EPU_DW-1:0]     epc_nxt;
   logic                   elsa_we;
   logic [`EPU_DW-1:0]     elsa_nxt;
   // High while a non-return exception commits
   logic                   exc_ent;

   modport src (output psr_we, psr_nxt, epsr_we, epsr_nxt, epc_we, epc_nxt,
                elsa_we, elsa_nxt, exc_ent);
   modport dst (input psr_we, psr_nxt, epsr_we, epsr_nxt, epc_we, epc_nxt,
                elsa_we, elsa_nxt, exc_ent);
endinterface

// File: source/epu_pkg.sv
// Package with the MSR write-data union (raw word or PSR field view)
`include "epu_defines.svh"

package epu_pkg;

   // Committed write word, decoded as PSR fields on a PSR write
   typedef union packed {
      logic [`EPU_DW-1:0] raw;
      struct packed {
         logic [`EPU_DW-`EPU_PSR_DW-1:0] rsvd;
         logic dce;
         logic ice;
         logic dmme;
         logic imme;
         logic ire;
         logic rm;
         // Condition flags
         logic [3:0] cc;
      } psr;
   } wmsr_dat_u;

endpackage

// File: source/epu_top.sv
// Module epu_top: exception processing unit top level
`timescale 1ns/1ps
`include "epu_defines.svh"

module epu_top (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    stall,
   input  logic                    ex_valid,
   input  logic [`EPU_OPC_W-1:0]   ex_opc,
   input  logic [`EPU_DW-1:0]      ex_operand1,
   input  logic [`EPU_DW-1:0]      ex_operand2,
   input  logic [`EPU_DW-1:0]      ex_imm,
   input  logic [`EPU_EXC_W-1:0]   commit_exc,
   input  logic [`EPU_PC_W-1:0]    commit_epc,
   input  logic [`EPU_PC_W-1:0]    commit_nepc,
   input  logic [`EPU_DW-1:0]      commit_lsa,
   input  logic                    commit_flush_tlb,
   input  logic [`EPU_PC_W-1:0]    commit_flush_tlb_npc,
   input  logic [`EPU_NUM_IRQ-1:0] irqs,
   output logic [`EPU_DW-1:0]      epu_dout,
   output logic                    epu_dout_valid,
   output logic                    epu_eret,
   output logic                    epu_esyscall,
   output logic                    exc_flush,
   output logic [`EPU_PC_W-1:0]    exc_flush_tgt,
   output logic                    irq_async,
   output logic                    tsc_irq
);

   logic [`EPU_PSR_DW-1:0] psr;
   logic [`EPU_PSR_DW-1:0] epsr;
   logic [`EPU_DW-1:0]     epc;
   logic [`EPU_DW-1:0]     elsa;
   logic [`EPU_DW-1:0]     imr;
   logic [`EPU_DW-1:0]     irr;
   logic [`EPU_DW-1:0]     tsr;
   logic [`EPU_DW-1:0]     tcr;
   epu_pkg::wmsr_dat_u     psr_v;

   msr_wr_if  wr_bus ();
   msr_upd_if upd_bus ();

   // Field view of PSR for the interrupt enable
   assign psr_v.raw = {{(`EPU_DW-`EPU_PSR_DW){1'b0}}, psr};

   msr_access u_msr_access (
      .clk(clk), .arst_n(arst_n), .stall(stall),
      .ex_valid(ex_valid), .ex_opc(ex_opc),
      .ex_operand1(ex_operand1), .ex_operand2(ex_operand2), .ex_imm(ex_imm),
      .psr(psr), .epsr(epsr), .epc(epc), .elsa(elsa),
      .imr(imr), .irr(irr), .tsr(tsr), .tcr(tcr),
      .epu_dout(epu_dout), .epu_dout_valid(epu_dout_valid),
      .epu_eret(epu_eret), .epu_esyscall(epu_esyscall),
      .wr(wr_bus.src)
   );

   exc_commit u_exc_commit (
      .clk(clk), .arst_n(arst_n), .stall(stall),
      .commit_exc(commit_exc), .commit_epc(commit_epc), .commit_nepc(commit_nepc),
      .commit_lsa(commit_lsa), .commit_flush_tlb(commit_flush_tlb),
      .commit_flush_tlb_npc(commit_flush_tlb_npc),
      .epc(epc), .psr(psr), .epsr(epsr),
      .wr(wr_bus.dst), .upd(upd_bus.src),
      .exc_flush(exc_flush), .exc_flush_tgt(exc_flush_tgt)
   );

   msr_file u_msr_file (
      .clk(clk), .arst_n(arst_n), .upd(upd_bus.dst),
      .psr(psr), .epsr(epsr), .epc(epc), .elsa(elsa)
   );

   irq_ctrl u_irq_ctrl (
      .clk(clk), .arst_n(arst_n), .wr(wr_bus.dst),
      .irqs(irqs), .psr_ire(psr_v.psr.ire),
      .imr(imr), .irr(irr), .irq_async(irq_async)
   );

   tsc_timer u_tsc_timer (
      .clk(clk), .arst_n(arst_n), .wr(wr_bus.dst),
      .tsr(tsr), .tcr(tcr), .tsc_irq(tsc_irq)
   );

endmodule

// File: source/exc_commit.sv
// Module exc_commit: next values for PSR, EPSR, EPC and ELSA, flush target and entry edge
`timescale 1ns/1ps
`include "epu_defines.svh"

module exc_commit (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   stall,
   input  logic [`EPU_EXC_W-1:0]  commit_exc,
   input  logic [`EPU_PC_W-1:0]   commit_epc,
   input  logic [`EPU_PC_W-1:0]   commit_nepc,
   input  logic [`EPU_DW-1:0]     commit_lsa,
   input  logic                   commit_flush_tlb,
   input  logic [`EPU_PC_W-1:0]   commit_flush_tlb_npc,
   input  logic [`EPU_DW-1:0]     epc,
   input  logic [`EPU_PSR_DW-1:0] psr,
   input  logic [`EPU_PSR_DW-1:0] epsr,
   msr_wr_if.dst                  wr,
   msr_upd_if.src                 upd,
   output logic                   exc_flush,
   output logic [`EPU_PC_W-1:0]   exc_flush_tgt
);

   // Indexed by exception, ERET has no vector
   localparam logic [`EPU_DW-1:0] exc_vec [`EPU_EXC_W] = '{
      32'h0, `EPU_VEC_ESYSCALL, `EPU_VEC_EINSN, `EPU_VEC_EIPF, `EPU_VEC_EITM,
      `EPU_VEC_EIRQ, `EPU_VEC_EDTM, `EPU_VEC_EDPF, `EPU_VEC_EALIGN
   };

   logic               eret;
   logic               exc_ent;
   logic               exc_ent_q;
   logic               elsa_as_pc;
   logic               elsa_set;
   epu_pkg::wmsr_dat_u epsr_v;
   epu_pkg::wmsr_dat_u psr_n;

   assign eret    = commit_exc[`EPU_EXC_ERET];
   assign exc_ent = |commit_exc & ~eret;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         exc_ent_q <= 1'b0;
      end else begin
         exc_ent_q <= exc_ent;
      end
   end

   // ERET restores the mode fields from EPSR, cache enables and flags stay
   always_comb begin
      epsr_v.raw = {{(`EPU_DW-`EPU_PSR_DW){1'b0}}, epsr};
      psr_n.raw  = {{(`EPU_DW-`EPU_PSR_DW){1'b0}}, psr};
      if (wr.psr_we) begin
         psr_n = wr.dat;
      end else begin
         psr_n.psr.rm   = epsr_v.psr.rm;
         psr_n.psr.ire  = epsr_v.psr.ire;
         psr_n.psr.imme = epsr_v.psr.imme;
         psr_n.psr.dmme = epsr_v.psr.dmme;
      end
   end

   assign upd.psr_we  = wr.psr_we | eret;
   assign upd.psr_nxt = psr_n.raw[`EPU_PSR_DW-1:0];
   assign upd.exc_ent = exc_ent;

   // Old PSR saved only on the first cycle of entry
   assign upd.epsr_we  = wr.epsr_we | (exc_ent & ~exc_ent_q);
   assign upd.epsr_nxt = wr.epsr_we ? wr.dat.raw[`EPU_PSR_DW-1:0] : psr;

   // SYSCALL resumes after the trap, other exceptions at the faulting insn
   assign upd.epc_we  = wr.epc_we | exc_ent;
   assign upd.epc_nxt = wr.epc_we ? wr.dat.raw :
                        commit_exc[`EPU_EXC_ESYSCALL] ? {commit_nepc, 2'b00} :
                        {commit_epc, 2'b00};

   assign elsa_as_pc = commit_exc[`EPU_EXC_EITM] | commit_exc[`EPU_EXC_EIPF] |
                       commit_exc[`EPU_EXC_EINSN];
   assign elsa_set   = elsa_as_pc | commit_exc[`EPU_EXC_EDTM] |
                       commit_exc[`EPU_EXC_EDPF] | commit_exc[`EPU_EXC_EALIGN];

   assign upd.elsa_we  = elsa_set | wr.elsa_we;
   assign upd.elsa_nxt = !elsa_set ? wr.dat.raw :
                         elsa_as_pc ? {commit_epc, 2'b00} : commit_lsa;

   always_comb begin
      exc_flush_tgt = ({`EPU_PC_W{commit_flush_tlb}} & commit_flush_tlb_npc) |
                      ({`EPU_PC_W{eret}} & epc[`EPU_DW-1:2]);
      for (int i = 1; i < `EPU_EXC_W; i++) begin
         exc_flush_tgt = exc_flush_tgt | ({`EPU_PC_W{commit_exc[i]}} & exc_vec[i][`EPU_DW-1:2]);
      end
   end

   assign exc_flush = ~stall & (|commit_exc | commit_flush_tlb);

endmodule

// File: source/irq_ctrl.sv
// Module irq_ctrl: interrupt mask register, raw request view and asynchronous interrupt
`timescale 1ns/1ps
`include "epu_defines.svh"

module irq_ctrl (
   input  logic                    clk,
   input  logic                    arst_n,
   msr_wr_if.dst                   wr,
   input  logic [`EPU_NUM_IRQ-1:0] irqs,
   input  logic                    psr_ire,
   output logic [`EPU_DW-1:0]      imr,
   output logic [`EPU_DW-1:0]      irr,
   output logic                    irq_async
);

   // All lines masked out of reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         imr <= '1;
      end else if (wr.imr_we) begin
         imr <= wr.dat.raw;
      end
   end

   assign irr = {{(`EPU_DW-`EPU_NUM_IRQ){1'b0}}, irqs};

   assign irq_async = psr_ire & (|(irqs & ~imr[`EPU_NUM_IRQ-1:0]));

endmodule

// File: source/msr_access.sv
// Module msr_access: MSR address decode, read mux, exception strobes and commit-stage register
`timescale 1ns/1ps
`include "epu_defines.svh"

module msr_access (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   stall,
   input  logic                   ex_valid,
   input  logic [`EPU_OPC_W-1:0]  ex_opc,
   input  logic [`EPU_DW-1:0]     ex_operand1,
   input  logic [`EPU_DW-1:0]     ex_operand2,
   input  logic [`EPU_DW-1:0]     ex_imm,
   input  logic [`EPU_PSR_DW-1:0] psr,
   input  logic [`EPU_PSR_DW-1:0] epsr,
   input  logic [`EPU_DW-1:0]     epc,
   input  logic [`EPU_DW-1:0]     elsa,
   input  logic [`EPU_DW-1:0]     imr,
   input  logic [`EPU_DW-1:0]     irr,
   input  logic [`EPU_DW-1:0]     tsr,
   input  logic [`EPU_DW-1:0]     tcr,
   output logic [`EPU_DW-1:0]     epu_dout,
   output logic                   epu_dout_valid,
   output logic                   epu_eret,
   output logic                   epu_esyscall,
   msr_wr_if.src                  wr
);

   logic [`EPU_DW-1:0]          msr_addr;
   logic [`EPU_BANK_AW-1:0]     bank;
   logic [`EPU_BANK_OFF_AW-1:0] off;
   logic                        bank_ps;
   logic                        bank_irqc;
   logic                        bank_tsc;
   logic [`EPU_DW-1:0]          psr_ext;
   logic [`EPU_DW-1:0]          epsr_ext;
   logic [`EPU_DW-1:0]          dout_ps;
   logic [`EPU_DW-1:0]          dout_irqc;
   logic [`EPU_DW-1:0]          dout_tsc;
   logic                        wmsr;

   // Address is operand1 with the 15-bit immediate OR-ed in
   assign msr_addr = ex_operand1 | {{(`EPU_DW-15){1'b0}}, ex_imm[14:0]};
   assign bank = msr_addr[`EPU_BANK_AW+`EPU_BANK_OFF_AW-1:`EPU_BANK_OFF_AW];
   assign off  = msr_addr[`EPU_BANK_OFF_AW-1:0];

   assign bank_ps   = (bank == `EPU_BANK_PS);
   assign bank_irqc = (bank == `EPU_BANK_IRQC);
   assign bank_tsc  = (bank == `EPU_BANK_TSC);

   assign psr_ext  = {{(`EPU_DW-`EPU_PSR_DW){1'b0}}, psr};
   assign epsr_ext = {{(`EPU_DW-`EPU_PSR_DW){1'b0}}, epsr};

   assign dout_ps = ({`EPU_DW{off[`EPU_MSR_PSR]}} & psr_ext) |
                    ({`EPU_DW{off[`EPU_MSR_EPSR]}} & epsr_ext) |
                    ({`EPU_DW{off[`EPU_MSR_EPC]}} & epc) |
                    ({`EPU_DW{off[`EPU_MSR_ELSA]}} & elsa);
   assign dout_irqc = ({`EPU_DW{off[`EPU_MSR_IMR]}} & imr) |
                      ({`EPU_DW{off[`EPU_MSR_IRR]}} & irr);
   assign dout_tsc = ({`EPU_DW{off[`EPU_MSR_TSR]}} & tsr) |
                     ({`EPU_DW{off[`EPU_MSR_TCR]}} & tcr);

   assign epu_dout = ({`EPU_DW{bank_ps}} & dout_ps) |
                     ({`EPU_DW{bank_irqc}} & dout_irqc) |
                     ({`EPU_DW{bank_tsc}} & dout_tsc);

   assign epu_dout_valid = ex_valid & ex_opc[`EPU_OP_RMSR];
   assign epu_eret       = ex_valid & ex_opc[`EPU_OP_ERET];
   assign epu_esyscall   = ex_valid & ex_opc[`EPU_OP_ESYSCALL];

   assign wmsr = ex_valid & ex_opc[`EPU_OP_WMSR];

   // Write strobes into the commit stage, held during stall
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr.psr_we  <= 1'b0;
         wr.epsr_we <= 1'b0;
         wr.epc_we  <= 1'b0;
         wr.elsa_we <= 1'b0;
         wr.imr_we  <= 1'b0;
         wr.tsr_we  <= 1'b0;
         wr.tcr_we  <= 1'b0;
      end else if (!stall) begin
         wr.psr_we  <= wmsr & bank_ps & off[`EPU_MSR_PSR];
         wr.epsr_we <= wmsr & bank_ps & off[`EPU_MSR_EPSR];
         wr.epc_we  <= wmsr & bank_ps & off[`EPU_MSR_EPC];
         wr.elsa_we <= wmsr & bank_ps & off[`EPU_MSR_ELSA];
         wr.imr_we  <= wmsr & bank_irqc & off[`EPU_MSR_IMR];
         wr.tsr_we  <= wmsr & bank_tsc & off[`EPU_MSR_TSR];
         wr.tcr_we  <= wmsr & bank_tsc & off[`EPU_MSR_TCR];
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         wr.dat.raw <= ex_operand2;
      end
   end

endmodule

// File: source/msr_file.sv
// Module msr_file: PSR, EPSR, EPC and ELSA registers
`timescale 1ns/1ps
`include "epu_defines.svh"

module msr_file (
   input  logic                   clk,
   input  logic                   arst_n,
   msr_upd_if.dst                 upd,
   output logic [`EPU_PSR_DW-1:0] psr,
   output logic [`EPU_PSR_DW-1:0] epsr,
   output logic [`EPU_DW-1:0]     epc,
   output logic [`EPU_DW-1:0]     elsa
);

   epu_pkg::wmsr_dat_u psr_ent;

   // Entry switches to kernel mode with IRQs and MMUs off
   always_comb begin
      psr_ent.raw      = {{(`EPU_DW-`EPU_PSR_DW){1'b0}}, psr};
      psr_ent.psr.rm   = 1'b1;
      psr_ent.psr.ire  = 1'b0;
      psr_ent.psr.imme = 1'b0;
      psr_ent.psr.dmme = 1'b0;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         psr <= '0;
      end else if (upd.psr_we) begin
         psr <= upd.psr_nxt;
      end else if (upd.exc_ent) begin
         psr <= psr_ent.raw[`EPU_PSR_DW-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (upd.epsr_we) begin
         epsr <= upd.epsr_nxt;
      end
      if (upd.epc_we) begin
         epc <= upd.epc_nxt;
      end
      if (upd.elsa_we) begin
         elsa <= upd.elsa_nxt;
      end
   end

endmodule

// File: source/tsc_timer.sv
// Module tsc_timer: timestamp counter TSR, control register TCR and timer interrupt
`timescale 1ns/1ps
`include "epu_defines.svh"

module tsc_timer (
   input  logic               clk,
   input  logic               arst_n,
   msr_wr_if.dst              wr,
   output logic [`EPU_DW-1:0] tsr,
   output logic [`EPU_DW-1:0] tcr,
   output logic               tsc_irq
);

   logic cmp_hit;

   assign cmp_hit = (tsr[`EPU_TCR_CNT_W-1:0] == tcr[`EPU_TCR_CNT_W-1:0]);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tsr     <= '0;
         tcr     <= '0;
         tsc_irq <= 1'b0;
      end else begin
         // Software write overrides the count
         if (wr.tsr_we) begin
            tsr <= wr.dat.raw;
         end else if (tcr[`EPU_TCR_EN]) begin
            tsr <= tsr + 1'b1;
         end
         if (wr.tcr_we) begin
            tcr <= wr.dat.raw;
         end
         // Sticky until TCR is rewritten
         if (wr.tcr_we) begin
            tsc_irq <= 1'b0;
         end else if (tcr[`EPU_TCR_IE] && cmp_hit) begin
            tsc_irq <= 1'b1;
         end
      end
   end

endmodule
